// File: source/mdc_pkg.sv
`default_nettype none

package mdc_pkg;

    // ========================================
    // widths
    // ========================================
    // decoded element and its hamming code word
    localparam int ELEM_W = 11;
    localparam int CODE_W = 15;
    // decoded mode and its code word
    localparam int MODE_W = 5;
    localparam int MODE_CODE_W = 9;
    // 2x2 minor, one bit of headroom over the raw product difference
    localparam int MINOR_W = 23;
    localparam int DET_W = 46;
    localparam int OUT_W = 207;

    // ========================================
    // counts
    // ========================================
    localparam int N_ELEMS = 16;
    localparam int CNT_W = 5;
    // counter value of the output cycle
    localparam int OUT_CNT = 17;
    // two rows of four
    localparam int WIN_LEN = 8;
    localparam int N_ADJ = 9;
    // rows 0/1 minors, one per column pair
    localparam int N_TOP = 6;
    // up to three laplace terms share the last element
    localparam int TERM_LANES = 3;

    // decoded mode values
    localparam logic [MODE_W-1:0] MODE_CODE_2X2 = 5'b00100;
    localparam logic [MODE_W-1:0] MODE_CODE_3X3 = 5'b00110;
    localparam logic [MODE_W-1:0] MODE_CODE_4X4 = 5'b10110;

    typedef enum logic [1:0] {MODE_2X2, MODE_4X4, MODE_NONE} mode_t;

    typedef enum logic [1:0] {PH_IDLE, PH_LOAD, PH_DRAIN, PH_OUT} phase_t;

endpackage

`default_nettype wire

// File: source/hamming_decoder.sv
`timescale 1ns/1ns
`default_nettype none

// single error correcting decode, positions 1..n counted from the msb
module hamming_decoder #(
    parameter int DATA_W = 11,
    // smallest parity count that covers data plus parity positions
    localparam int PAR_W = (DATA_W <= 1) ? 2 :
                           (DATA_W <= 4) ? 3 :
                           (DATA_W <= 11) ? 4 :
                           (DATA_W <= 26) ? 5 : 6,
    localparam int CODE_LEN = DATA_W + PAR_W
) (
    input  logic [CODE_LEN-1:0]      code,
    output logic signed [DATA_W-1:0] data
);

    logic [PAR_W-1:0]    syndrome;
    logic [CODE_LEN-1:0] fixed;

    // syndrome is the xor of every set position
    always_comb begin
        syndrome = '0;
        for (int p = 1; p <= CODE_LEN; p++) begin
            if (code[CODE_LEN - p]) begin
                syndrome = syndrome ^ PAR_W'(p);
            end
        end
    end

    // flip the flagged position, out of range syndromes left alone
    always_comb begin
        fixed = code;
        if (syndrome != '0 && int'(syndrome) <= CODE_LEN) begin
            fixed[CODE_LEN - int'(syndrome)] = ~code[CODE_LEN - int'(syndrome)];
        end
    end

    // strip parity at power of two positions, data kept msb first
    always_comb begin
        int k;
        k = DATA_W - 1;
        data = '0;
        for (int p = 1; p <= CODE_LEN; p++) begin
            if ((p & (p - 1)) != 0) begin
                data[k] = fixed[CODE_LEN - p];
                k = k - 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/mdc_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module mdc_sequencer
    import mdc_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  logic [MODE_W-1:0] mode_dec,
    output logic [CNT_W-1:0]  cnt,
    output phase_t            phase,
    output mode_t             mode,
    output logic              out_valid
);

    // ========================================
    // frame counter
    // ========================================
    // 0..15 loading, 16 drain, 17 output
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cnt == CNT_W'(OUT_CNT)) begin
            cnt <= '0;
        end else if (in_valid || cnt != '0) begin
            cnt <= cnt + 1'b1;
        end
    end

    // ========================================
    // mode latch
    // ========================================
    // mode word only meaningful alongside e0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= MODE_NONE;
        end else if (in_valid && cnt == '0) begin
            case (mode_dec)
                MODE_CODE_2X2: mode <= MODE_2X2;
                MODE_CODE_4X4: mode <= MODE_4X4;
                // 3x3 no longer supported, output stays zero
                MODE_CODE_3X3: mode <= MODE_NONE;
                default:       mode <= MODE_NONE;
            endcase
        end
    end

    // phase straight from the count
    always_comb begin
        if (cnt == CNT_W'(OUT_CNT)) begin
            phase = PH_OUT;
        end else if (cnt == CNT_W'(N_ELEMS)) begin
            phase = PH_DRAIN;
        end else if (in_valid || cnt != '0) begin
            phase = PH_LOAD;
        end else begin
            phase = PH_IDLE;
        end
    end

    // single cycle strobe
    assign out_valid = (phase == PH_OUT);

endmodule

`default_nettype wire

// File: source/minor_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module minor_datapath
    import mdc_pkg::*;
(
    input  logic                           clk,
    input  logic                           in_valid,
    input  logic signed [ELEM_W-1:0]       elem,
    input  logic [CNT_W-1:0]               cnt,
    input  mode_t                          mode,
    output logic [0:N_ADJ-1][MINOR_W-1:0]  adj_minor,
    output logic signed [MINOR_W-1:0]      top_minor [TERM_LANES],
    output logic signed [MINOR_W-1:0]      bottom_minor [TERM_LANES],
    output logic                           term_valid,
    output logic                           term_sign
);

    // win[7] newest element, win[0] oldest
    logic signed [ELEM_W-1:0]  win [WIN_LEN];
    // minor_unit[d] spans columns c-d and c of the last two rows
    logic signed [MINOR_W-1:0] minor_unit [1:3];
    // rows 0/1 minors, pairs 01 02 03 12 13 23
    logic signed [MINOR_W-1:0] top_m [N_TOP];

    // ========================================
    // element window
    // ========================================
    always_ff @(posedge clk) begin
        if (in_valid) begin
            for (int j = 0; j < WIN_LEN - 1; j++) begin
                win[j] <= win[j + 1];
            end
            win[WIN_LEN - 1] <= elem;
        end
    end

    // ========================================
    // minor units
    // ========================================
    // upper row sits four slots behind the lower row
    for (genvar d = 1; d <= 3; d++) begin : g_minor
        assign minor_unit[d] = win[3 - d] * win[WIN_LEN - 1]
                             - win[3] * win[WIN_LEN - 1 - d];
    end

    // adjacent minors, one count after their last element
    always_ff @(posedge clk) begin
        case (cnt)
            5'd6:  adj_minor[0] <= minor_unit[1];
            5'd7:  adj_minor[1] <= minor_unit[1];
            5'd8:  adj_minor[2] <= minor_unit[1];
            5'd10: adj_minor[3] <= minor_unit[1];
            5'd11: adj_minor[4] <= minor_unit[1];
            5'd12: adj_minor[5] <= minor_unit[1];
            5'd14: adj_minor[6] <= minor_unit[1];
            5'd15: adj_minor[7] <= minor_unit[1];
            5'd16: adj_minor[8] <= minor_unit[1];
            default: ;
        endcase
    end

    // all six top minors, ready once row 1 is in
    always_ff @(posedge clk) begin
        if (mode == MODE_4X4) begin
            case (cnt)
                5'd6: begin
                    top_m[0] <= minor_unit[1];
                end
                5'd7: begin
                    top_m[1] <= minor_unit[2];
                    top_m[3] <= minor_unit[1];
                end
                5'd8: begin
                    top_m[2] <= minor_unit[3];
                    top_m[4] <= minor_unit[2];
                    top_m[5] <= minor_unit[1];
                end
                default: ;
            endcase
        end
    end

    // ========================================
    // laplace terms
    // ========================================
    // lane i takes bottom pair (i, b), its partner is the complement pair
    // term_sign is lane 0, higher lanes alternate
    always_comb begin
        for (int i = 0; i < TERM_LANES; i++) begin
            top_minor[i] = '0;
            bottom_minor[i] = '0;
        end
        term_valid = 1'b0;
        term_sign = 1'b0;
        if (mode == MODE_4X4) begin
            case (cnt)
                // bottom 01 with top 23
                5'd14: begin
                    term_valid = 1'b1;
                    bottom_minor[0] = minor_unit[1];
                    top_minor[0] = top_m[5];
                end
                // bottom 02 and 12, lane 0 negative
                5'd15: begin
                    term_valid = 1'b1;
                    term_sign = 1'b1;
                    bottom_minor[0] = minor_unit[2];
                    top_minor[0] = top_m[4];
                    bottom_minor[1] = minor_unit[1];
                    top_minor[1] = top_m[2];
                end
                // bottom 03 13 23, all need e15
                5'd16: begin
                    term_valid = 1'b1;
                    bottom_minor[0] = minor_unit[3];
                    top_minor[0] = top_m[3];
                    bottom_minor[1] = minor_unit[2];
                    top_minor[1] = top_m[1];
                    bottom_minor[2] = minor_unit[1];
                    top_minor[2] = top_m[0];
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/laplace_accumulator.sv
`timescale 1ns/1ns
`default_nettype none

module laplace_accumulator
    import mdc_pkg::*;
(
    input  logic                      clk,
    input  logic signed [MINOR_W-1:0] top_minor [TERM_LANES],
    input  logic signed [MINOR_W-1:0] bottom_minor [TERM_LANES],
    input  logic                      term_valid,
    input  logic                      term_sign,
    input  logic                      out_valid,
    output logic signed [DET_W-1:0]   det
);

    logic signed [DET_W-1:0] lane_prod [TERM_LANES];
    logic signed [DET_W-1:0] term_sum;
    // previous cycle already added terms of this frame
    logic                    term_run;

    // ========================================
    // products
    // ========================================
    // 23x23 fits the 46 bit determinant
    for (genvar i = 0; i < TERM_LANES; i++) begin : g_lane
        assign lane_prod[i] = top_minor[i] * bottom_minor[i];
    end

    // signed sum over the lanes
    always_comb begin
        term_sum = '0;
        for (int i = 0; i < TERM_LANES; i++) begin
            // checkerboard, neighbours in a row of terms flip sign
            if (term_sign ^ i[0]) begin
                term_sum = term_sum - lane_prod[i];
            end else begin
                term_sum = term_sum + lane_prod[i];
            end
        end
    end

    // ========================================
    // accumulation
    // ========================================
    always_ff @(posedge clk) begin
        term_run <= term_valid;
    end

    // first term of a run loads, later ones add
    always_ff @(posedge clk) begin
        if (out_valid) begin
            det <= '0;
        end else if (term_valid) begin
            if (term_run) begin
                det <= det + term_sum;
            end else begin
                det <= term_sum;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/result_formatter.sv
`timescale 1ns/1ns
`default_nettype none

module result_formatter
    import mdc_pkg::*;
(
    input  logic                          out_valid,
    input  mode_t                         mode,
    input  logic [0:N_ADJ-1][MINOR_W-1:0] adj_minor,
    input  logic signed [DET_W-1:0]       det,
    output logic [OUT_W-1:0]              out_data
);

    // ========================================
    // output packing
    // ========================================
    // zero outside the output cycle
    always_comb begin
        out_data = '0;
        if (out_valid) begin
            case (mode)
                // minor 0 lands in the top 23 bits
                MODE_2X2: begin
                    out_data = adj_minor;
                end
                // determinant sign extended over the whole bus
                MODE_4X4: begin
                    out_data = {{(OUT_W - DET_W){det[DET_W-1]}}, det};
                end
                // 3x3 or unknown code
                default: begin
                    out_data = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/mdc.sv
`timescale 1ns/1ns
`default_nettype none

module mdc
    import mdc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic [CODE_W-1:0]      in_data,
    input  logic [MODE_CODE_W-1:0] in_mode,
    output logic                   out_valid,
    output logic [OUT_W-1:0]       out_data
);

    logic signed [ELEM_W-1:0]      elem;
    logic [MODE_W-1:0]             mode_dec;
    logic [CNT_W-1:0]              cnt;
    mode_t                         mode;
    logic [0:N_ADJ-1][MINOR_W-1:0] adj_minor;
    logic signed [MINOR_W-1:0]     top_minor [TERM_LANES];
    logic signed [MINOR_W-1:0]     bottom_minor [TERM_LANES];
    logic                          term_valid;
    logic                          term_sign;
    logic signed [DET_W-1:0]       det;

    // ========================================
    // decoders
    // ========================================
    hamming_decoder #(.DATA_W(ELEM_W)) u_elem_dec (
        .code (in_data),
        .data (elem)
    );

    hamming_decoder #(.DATA_W(MODE_W)) u_mode_dec (
        .code (in_mode),
        .data (mode_dec)
    );

    // ========================================
    // control and datapath
    // ========================================
    mdc_sequencer u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .mode_dec  (mode_dec),
        .cnt       (cnt),
        .phase     (),
        .mode      (mode),
        .out_valid (out_valid)
    );

    minor_datapath u_dp (
        .clk          (clk),
        .in_valid     (in_valid),
        .elem         (elem),
        .cnt          (cnt),
        .mode         (mode),
        .adj_minor    (adj_minor),
        .top_minor    (top_minor),
        .bottom_minor (bottom_minor),
        .term_valid   (term_valid),
        .term_sign    (term_sign)
    );

    laplace_accumulator u_acc (
        .clk          (clk),
        .top_minor    (top_minor),
        .bottom_minor (bottom_minor),
        .term_valid   (term_valid),
        .term_sign    (term_sign),
        .out_valid    (out_valid),
        .det          (det)
    );

    result_formatter u_fmt (
        .out_valid (out_valid),
        .mode      (mode),
        .adj_minor (adj_minor),
        .det       (det),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// File: dv/mdc_checker.sv
`timescale 1ns/1ns
`default_nettype none

// port level protocol checks, bound into every mdc
module mdc_checker
    import mdc_pkg::*;
(
    input logic             clk,
    input logic             rst_n,
    input logic             in_valid,
    input logic             out_valid,
    input logic [OUT_W-1:0] out_data
);

    // ========================================
    // output strobe timing
    // ========================================
    // no result while a matrix is still streaming in
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !in_valid)
        else $error("out_valid high while in_valid is high");

    // drain cycle after the fall, then the result
    a_after_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(in_valid) |=> out_valid)
        else $error("out_valid missing two cycles after the last input");

    // a rise only ever comes from a finished frame
    a_rise_source: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_valid) |-> $past(in_valid, 2) && !$past(in_valid))
        else $error("out_valid rose without a matrix two cycles before");

    // single cycle pulse
    a_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
        else $error("out_valid high for more than one cycle");

    // ========================================
    // output data
    // ========================================
    a_zero_data: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> out_data == '0)
        else $error("out_data nonzero while out_valid is low");

endmodule

bind mdc mdc_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_data  (out_data)
);

`default_nettype wire

// File: dv/tb_mdc.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mdc
    import mdc_pkg::*;
();

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    logic [CODE_W-1:0]      in_data;
    logic [MODE_CODE_W-1:0] in_mode;
    logic                   out_valid;
    logic [OUT_W-1:0]       out_data;

    logic [15:0]            lfsr;
    // current matrix, row major
    int                     mat [N_ELEMS];
    logic [OUT_W-1:0]       expected;

    mdc mdc_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_mode   (in_mode),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ========================================
    // random source and encoder
    // ========================================
    // x^16 + x^14 + x^13 + x^11 + 1, new bit enters at the lsb
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one step per bit taken
    task automatic draw_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    // positions 1..n from the msb, parity at powers of two
    function automatic logic [14:0] hamming_encode(input logic [10:0] d, input int data_w);
        int n;
        int k;
        int syn;
        logic [14:0] c;
        n = data_w + 4;
        k = data_w - 1;
        syn = 0;
        c = '0;
        for (int p = 1; p <= n; p++) begin
            if ((p & (p - 1)) != 0) begin
                c[n - p] = d[k];
                if (d[k]) begin
                    syn = syn ^ p;
                end
                k = k - 1;
            end
        end
        // parity bits cancel the data syndrome
        for (int j = 0; j < 4; j++) begin
            if (syn[j]) begin
                c[n - (1 << j)] = 1'b1;
            end
        end
        return c;
    endfunction

    // ========================================
    // reference model
    // ========================================
    function automatic int minor2(input int r, input int c);
        return mat[4*r + c] * mat[4*r + 5 + c] - mat[4*r + c + 1] * mat[4*r + 4 + c];
    endfunction

    // 3x3 determinant of rows 1..3 over three columns
    function automatic longint cofactor3(input int c0, input int c1, input int c2);
        return longint'(mat[4 + c0]) * (longint'(mat[8 + c1]) * mat[12 + c2]
                                      - longint'(mat[8 + c2]) * mat[12 + c1])
             - longint'(mat[4 + c1]) * (longint'(mat[8 + c0]) * mat[12 + c2]
                                      - longint'(mat[8 + c2]) * mat[12 + c0])
             + longint'(mat[4 + c2]) * (longint'(mat[8 + c0]) * mat[12 + c1]
                                      - longint'(mat[8 + c1]) * mat[12 + c0]);
    endfunction

    // expansion along row 0
    function automatic longint determinant4();
        return longint'(mat[0]) * cofactor3(1, 2, 3) - longint'(mat[1]) * cofactor3(0, 2, 3)
             + longint'(mat[2]) * cofactor3(0, 1, 3) - longint'(mat[3]) * cofactor3(0, 1, 2);
    endfunction

    // mode 0 is 2x2, 1 is 4x4, 2 is the dropped 3x3
    task automatic build_expected(input int mode_sel);
        expected = '0;
        if (mode_sel == 0) begin
            for (int r = 0; r < 3; r++) begin
                for (int c = 0; c < 3; c++) begin
                    expected[OUT_W - 1 - MINOR_W*(3*r + c) -: MINOR_W] = MINOR_W'(minor2(r, c));
                end
            end
        end else if (mode_sel == 1) begin
            expected = OUT_W'(determinant4());
        end
    endtask

    // kind 0 full range, kind 1 only -1024 and 1023
    task automatic load_matrix(input int kind);
        int v;
        logic signed [ELEM_W-1:0] e;
        for (int k = 0; k < N_ELEMS; k++) begin
            if (kind == 1) begin
                draw_bits(1, v);
                mat[k] = (v != 0) ? -1024 : 1023;
            end else begin
                draw_bits(ELEM_W, v);
                e = v[ELEM_W-1:0];
                mat[k] = int'(e);
            end
        end
    endtask

    // ========================================
    // failure reporting
    // ========================================
    task automatic stop_run(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_failed(input string msg);
        stop_run($sformatf("CHECK FAILED at %0t ns: %s", $time, msg));
    endtask

    // ========================================
    // stimulus and checks
    // ========================================
    // one element per cycle, mode word only with e0
    task automatic send_matrix(input logic [MODE_W-1:0] mode_val, input bit inject);
        logic [CODE_W-1:0] word;
        logic [14:0] full;
        int v;
        for (int k = 0; k < N_ELEMS; k++) begin
            @(posedge clk);
            #1;
            word = hamming_encode(mat[k][ELEM_W-1:0], ELEM_W);
            if (inject) begin
                draw_bits(4, v);
                word[v % CODE_W] = ~word[v % CODE_W];
            end
            in_valid = 1'b1;
            in_data = word;
            draw_bits(MODE_CODE_W, v);
            if (k == 0) begin
                full = hamming_encode({6'b0, mode_val}, MODE_W);
                in_mode = full[MODE_CODE_W-1:0];
                if (inject) begin
                    in_mode[v % MODE_CODE_W] = ~in_mode[v % MODE_CODE_W];
                end
            end else begin
                // ignored after the first cycle
                in_mode = v[MODE_CODE_W-1:0];
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_data = '0;
        in_mode = '0;
    endtask

    // outputs sampled on the falling edge
    task automatic wait_and_check(input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (out_valid !== 1'b1) begin
                assert (out_data == '0)
                    else check_failed($sformatf("%s: out_data nonzero before out_valid", what));
            end
        end while (out_valid !== 1'b1 && n < 20);
        if (out_valid !== 1'b1) begin
            stop_run($sformatf("timeout: %s got no out_valid within 20 cycles", what));
        end
        assert (n == 2)
            else check_failed($sformatf("%s: out_valid %0d cycles after last input", what, n));
        assert (out_data === expected)
            else check_failed($sformatf("%s: out_data %h, expected %h", what, out_data, expected));
    endtask

    // gap of idle cycles, zero means back to back
    task automatic run_matrix(input int mode_sel, input int kind, input bit inject,
                              input int gap, input string what);
        logic [MODE_W-1:0] mode_val;
        repeat (gap) @(posedge clk);
        load_matrix(kind);
        build_expected(mode_sel);
        case (mode_sel)
            0:       mode_val = MODE_CODE_2X2;
            1:       mode_val = MODE_CODE_4X4;
            default: mode_val = MODE_CODE_3X3;
        endcase
        send_matrix(mode_val, inject);
        wait_and_check(what);
    endtask

    initial begin
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        in_mode = '0;
        lfsr = 16'd81;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // clean 2x2, extremes first
        run_matrix(0, 1, 1'b0, 3, "2x2 extremes");
        for (int i = 0; i < 3; i++) begin
            run_matrix(0, 0, 1'b0, 2, "2x2 random");
        end
        // clean 4x4
        for (int i = 0; i < 4; i++) begin
            run_matrix(1, 0, 1'b0, 2, "4x4 random");
        end
        run_matrix(1, 1, 1'b0, 2, "4x4 extremes");
        // one flipped bit per word
        for (int i = 0; i < 4; i++) begin
            run_matrix(i % 2, 0, 1'b1, 2, "single bit error");
        end
        // 3x3 code, zero result
        run_matrix(2, 0, 1'b0, 2, "3x3 clean");
        run_matrix(2, 0, 1'b1, 2, "3x3 single bit error");
        // back to back, modes alternating
        for (int i = 0; i < 6; i++) begin
            run_matrix(i % 2, 0, i >= 3, 0, "back to back");
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: mdc.f
source/mdc_pkg.sv
source/hamming_decoder.sv
source/mdc_sequencer.sv
source/minor_datapath.sv
source/laplace_accumulator.sv
source/result_formatter.sv
source/mdc.sv
dv/mdc_checker.sv
dv/tb_mdc.sv

// File: Makefile
# verilator build and run of the mdc testbench

BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_mdc with verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_mdc -f mdc.f \
		--Mdir $(BUILD) -o tb_mdc
	./$(BUILD)/tb_mdc | tee $(LOG)
	@grep -q "^test passed$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
